// File: l2_cache_pkg.sv
/*
 Shared sizes, address fields and enums for the four-way L2 cache.
 Every design module imports what it needs from here.
*/
package l2_cache_pkg;

    localparam int ADDR_W = 32;            // byte address
    localparam int WORD_W = 128;           // requester word
    localparam int LINE_W = 512;           // one cache line
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;

    localparam int OFFSET_LO = 4;          // 16-byte words
    localparam int OFFSET_W = $clog2(WORDS_PER_LINE);
    localparam int INDEX_LO = OFFSET_LO + OFFSET_W;
    localparam int INDEX_W = 4;
    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int TAG_W = ADDR_W - INDEX_LO - INDEX_W;

    localparam int NUM_WAYS = 4;
    localparam int LINE_ADDR_W = ADDR_W - INDEX_LO;  // memory side addresses whole lines

    typedef logic [$clog2(NUM_WAYS)-1:0] way_t;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_RESP,
        ST_WB_REQ,       // dirty victim goes out first
        ST_FILL_REQ,
        ST_FILL_WAIT
    } l2_state_e;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

// File: l2_tag_dir.sv
/*
 Tag directory of the L2 cache: tag, valid and dirty per way and set, plus tree PLRU.
 Hit and victim are answered combinationally, updates land on the next edge.
*/
module l2_tag_dir (
    input  logic                                clk_tmp,
    input  logic                                rst,
    input  logic [l2_cache_pkg::INDEX_W-1:0]    index,
    input  logic [l2_cache_pkg::TAG_W-1:0]      tag,
    input  l2_cache_pkg::way_t                  sel_way,
    input  logic                                tag_fill,
    input  logic                                touch,
    input  logic                                set_dirty,
    output logic                                hit,
    output l2_cache_pkg::way_t                  hit_way,
    output l2_cache_pkg::way_t                  victim_way,
    output logic                                victim_dirty,
    output logic [l2_cache_pkg::TAG_W-1:0]      victim_tag
);
    import l2_cache_pkg::*;

    logic [TAG_W-1:0]                   tag_mem [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]  valid_q;
    logic [NUM_SETS-1:0][NUM_WAYS-1:0]  dirty_q;
    logic [NUM_SETS-1:0][2:0]           plru_q;   // [0] picks half, [1] ways 0/1, [2] ways 2/3
    logic [NUM_WAYS-1:0]                way_valid;
    logic [NUM_WAYS-1:0]                way_match;
    logic [2:0]                         tree;

    assign way_valid = valid_q[index];
    assign tree = plru_q[index];

    // tag compare across all ways
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_match[w] = way_valid[w] && (tag_mem[w][index] == tag);
            if (way_match[w]) begin
                hit = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // lowest invalid way wins, otherwise follow the tree
    always_comb begin
        victim_way = way_t'({tree[0], tree[0] ? tree[2] : tree[1]});
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!way_valid[w]) begin
                victim_way = way_t'(w);
            end
        end
    end

    assign victim_dirty = way_valid[victim_way] && dirty_q[index][victim_way];
    assign victim_tag = tag_mem[victim_way][index];

    always_ff @(posedge clk_tmp) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
            plru_q <= '0;
        end else begin
            if (tag_fill) begin
                valid_q[index][sel_way] <= 1'b1;  // refilled line starts clean
                dirty_q[index][sel_way] <= 1'b0;
            end else if (set_dirty) begin
                dirty_q[index][sel_way] <= 1'b1;
            end
            if (touch) begin
                if (sel_way[1]) begin
                    plru_q[index][0] <= 1'b0;    // point back to ways 0/1
                    plru_q[index][2] <= ~sel_way[0];
                end else begin
                    plru_q[index][0] <= 1'b1;    // point to ways 2/3
                    plru_q[index][1] <= ~sel_way[0];
                end
            end
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (tag_fill) begin
            tag_mem[sel_way][index] <= tag;
        end
    end

endmodule

// File: l2_data_store.sv
/*
 Line storage of the L2 cache, one 512-bit line per way and set.
 Read side is combinational, word merge and line fill write on the next edge.
*/
module l2_data_store (
    input  logic                                clk_tmp,
    input  logic [l2_cache_pkg::INDEX_W-1:0]    index,
    input  logic [l2_cache_pkg::OFFSET_W-1:0]   offset,
    input  l2_cache_pkg::way_t                  sel_way,
    input  logic                                word_we,
    input  logic [l2_cache_pkg::WORD_W-1:0]     req_wdata,
    input  logic                                line_we,
    input  logic [l2_cache_pkg::LINE_W-1:0]     mem_rdata,
    output logic [l2_cache_pkg::WORD_W-1:0]     rd_word,
    output logic [l2_cache_pkg::LINE_W-1:0]     rd_line
);
    import l2_cache_pkg::*;

    logic [LINE_W-1:0] line_mem [NUM_WAYS][NUM_SETS];

    assign rd_line = line_mem[sel_way][index];
    assign rd_word = rd_line[offset*WORD_W +: WORD_W];   // word select within the line

    always_ff @(posedge clk_tmp) begin
        if (line_we) begin
            line_mem[sel_way][index] <= mem_rdata;       // whole-line refill
        end else if (word_we) begin
            line_mem[sel_way][index][offset*WORD_W +: WORD_W] <= req_wdata;
        end
    end

endmodule

// File: l2_cache_ctrl.sv
/*
 L2 cache controller: captures one request, looks it up, handles write-back and refill.
 Drives the tag directory and data store strobes and both external handshakes.
*/
module l2_cache_ctrl (
    input  logic                                    clk_tmp,
    input  logic                                    rst,
    input  logic                                    req_valid,
    input  logic                                    req_write,
    input  logic [l2_cache_pkg::ADDR_W-1:0]         req_addr,
    input  logic [l2_cache_pkg::WORD_W-1:0]         req_wdata,
    output logic                                    req_ready,
    output logic                                    rsp_valid,
    output logic [l2_cache_pkg::WORD_W-1:0]         rsp_rdata,
    input  logic                                    rsp_ready,
    output logic                                    mem_req_valid,
    output l2_cache_pkg::mem_op_e                   mem_op,
    output logic [l2_cache_pkg::LINE_ADDR_W-1:0]    mem_addr,
    output logic [l2_cache_pkg::LINE_W-1:0]         mem_wdata,
    input  logic                                    mem_req_ready,
    input  logic                                    mem_rsp_valid,
    output logic [l2_cache_pkg::INDEX_W-1:0]        index,
    output logic [l2_cache_pkg::TAG_W-1:0]          tag,
    output logic                                    tag_fill,
    output logic                                    touch,
    output logic                                    set_dirty,
    output l2_cache_pkg::way_t                      sel_way,
    input  logic                                    hit,
    input  l2_cache_pkg::way_t                      hit_way,
    input  l2_cache_pkg::way_t                      victim_way,
    input  logic                                    victim_dirty,
    input  logic [l2_cache_pkg::TAG_W-1:0]          victim_tag,
    output logic [l2_cache_pkg::OFFSET_W-1:0]       offset,
    output logic                                    word_we,
    output logic                                    line_we,
    output logic [l2_cache_pkg::WORD_W-1:0]         store_wdata,
    input  logic [l2_cache_pkg::WORD_W-1:0]         rd_word,
    input  logic [l2_cache_pkg::LINE_W-1:0]         rd_line
);
    import l2_cache_pkg::*;

    l2_state_e          state;
    logic               req_write_q;
    logic [ADDR_W-1:0]  req_addr_q;
    logic [WORD_W-1:0]  req_wdata_q;
    logic               accept;
    logic               lookup;
    logic               fill_done;

    assign accept = req_valid && req_ready;
    assign lookup = (state == ST_LOOKUP);
    assign fill_done = (state == ST_FILL_WAIT) && mem_rsp_valid;

    // address fields of the held request
    assign index = req_addr_q[INDEX_LO +: INDEX_W];
    assign tag = req_addr_q[ADDR_W-1 -: TAG_W];
    assign offset = req_addr_q[OFFSET_LO +: OFFSET_W];
    assign store_wdata = req_wdata_q;

    // victim way stays put for the whole miss, arrays only change at the fill edge
    assign sel_way = lookup ? hit_way : victim_way;
    assign touch = lookup && hit;
    assign word_we = touch && req_write_q;   // write hit merges at the lookup edge
    assign set_dirty = word_we;
    assign tag_fill = fill_done;
    assign line_we = fill_done;

    assign req_ready = (state == ST_IDLE);
    assign rsp_valid = (state == ST_RESP);

    assign mem_req_valid = (state == ST_WB_REQ) || (state == ST_FILL_REQ);
    assign mem_op = (state == ST_WB_REQ) ? MEM_WRITE : MEM_READ;
    assign mem_addr = (state == ST_WB_REQ) ? {victim_tag, index}
                                           : req_addr_q[ADDR_W-1:INDEX_LO];
    assign mem_wdata = rd_line;              // victim line while in ST_WB_REQ

    always_ff @(posedge clk_tmp) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    if (hit) begin
                        state <= ST_RESP;
                    end else if (victim_dirty) begin
                        state <= ST_WB_REQ;
                    end else begin
                        state <= ST_FILL_REQ;       // clean or empty victim, no writeback
                    end
                end
                ST_RESP: begin
                    if (rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                ST_WB_REQ: begin
                    if (mem_req_ready) begin
                        state <= ST_FILL_REQ;
                    end
                end
                ST_FILL_REQ: begin
                    if (mem_req_ready) begin
                        state <= ST_FILL_WAIT;
                    end
                end
                ST_FILL_WAIT: begin
                    if (mem_rsp_valid) begin
                        state <= ST_LOOKUP;         // repeat lookup now hits
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_tmp) begin
        if (accept) begin
            req_write_q <= req_write;
            req_addr_q <= req_addr;
            req_wdata_q <= req_wdata;
        end
        if (touch) begin
            rsp_rdata <= rd_word;   // don't care for writes
        end
    end

endmodule

// File: l2_cache.sv
/*
 Top level of the four-way write-back L2 cache with one requester and one memory port.
 Connects the controller to the tag directory and the data store.
*/
module l2_cache (
    input  logic                                    clk_tmp,
    input  logic                                    rst,
    input  logic                                    req_valid,
    input  logic                                    req_write,
    input  logic [l2_cache_pkg::ADDR_W-1:0]         req_addr,
    input  logic [l2_cache_pkg::WORD_W-1:0]         req_wdata,
    output logic                                    req_ready,
    output logic                                    rsp_valid,
    output logic [l2_cache_pkg::WORD_W-1:0]         rsp_rdata,
    input  logic                                    rsp_ready,
    output logic                                    mem_req_valid,
    output l2_cache_pkg::mem_op_e                   mem_op,
    output logic [l2_cache_pkg::LINE_ADDR_W-1:0]    mem_addr,
    output logic [l2_cache_pkg::LINE_W-1:0]         mem_wdata,
    input  logic                                    mem_req_ready,
    input  logic                                    mem_rsp_valid,
    input  logic [l2_cache_pkg::LINE_W-1:0]         mem_rdata
);
    import l2_cache_pkg::*;

    logic [INDEX_W-1:0]     index;
    logic [TAG_W-1:0]       tag;
    logic [OFFSET_W-1:0]    offset;
    way_t                   sel_way;
    logic                   tag_fill;
    logic                   touch;
    logic                   set_dirty;
    logic                   hit;
    way_t                   hit_way;
    way_t                   victim_way;
    logic                   victim_dirty;
    logic [TAG_W-1:0]       victim_tag;
    logic                   word_we;
    logic                   line_we;
    logic [WORD_W-1:0]      store_wdata;    // request word held by the controller
    logic [WORD_W-1:0]      rd_word;
    logic [LINE_W-1:0]      rd_line;

    l2_cache_ctrl u_ctrl (
        .clk_tmp(clk_tmp), .rst(rst),
        .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_ready(req_ready),
        .rsp_valid(rsp_valid), .rsp_rdata(rsp_rdata), .rsp_ready(rsp_ready),
        .mem_req_valid(mem_req_valid), .mem_op(mem_op), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_req_ready(mem_req_ready), .mem_rsp_valid(mem_rsp_valid),
        .index(index), .tag(tag), .tag_fill(tag_fill), .touch(touch),
        .set_dirty(set_dirty), .sel_way(sel_way),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag),
        .offset(offset), .word_we(word_we), .line_we(line_we), .store_wdata(store_wdata),
        .rd_word(rd_word), .rd_line(rd_line)
    );

    l2_tag_dir u_tag (
        .clk_tmp(clk_tmp), .rst(rst), .index(index), .tag(tag), .sel_way(sel_way),
        .tag_fill(tag_fill), .touch(touch), .set_dirty(set_dirty),
        .hit(hit), .hit_way(hit_way), .victim_way(victim_way),
        .victim_dirty(victim_dirty), .victim_tag(victim_tag)
    );

    l2_data_store u_data (
        .clk_tmp(clk_tmp), .index(index), .offset(offset), .sel_way(sel_way),
        .word_we(word_we), .req_wdata(store_wdata), .line_we(line_we),
        .mem_rdata(mem_rdata), .rd_word(rd_word), .rd_line(rd_line)
    );

endmodule

// File: l2_cache_checker.sv
/*
 Handshake assertions for the L2 cache requester and memory ports, attached with bind.
 assert_errors counts failed assertions.
*/
module l2_cache_checker (
    input logic                                 clk_tmp,
    input logic                                 rst,
    input logic                                 req_ready,
    input logic                                 rsp_valid,
    input logic                                 rsp_ready,
    input logic [l2_cache_pkg::WORD_W-1:0]      rsp_rdata,
    input logic                                 mem_req_valid,
    input logic                                 mem_req_ready,
    input logic                                 mem_op,
    input logic [l2_cache_pkg::LINE_ADDR_W-1:0] mem_addr,
    input logic [l2_cache_pkg::LINE_W-1:0]      mem_wdata
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_errors = 0;

    a_no_accept_in_resp: assert property (@(posedge clk_tmp) disable iff (rst)
        rsp_valid |-> !req_ready)
        else begin
            $error("req_ready high while a response is pending");
            assert_errors++;
        end

    a_rsp_hold: assert property (@(posedge clk_tmp) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata))
        else begin
            $error("response dropped or changed before rsp_ready");
            assert_errors++;
        end

    a_mem_req_hold: assert property (@(posedge clk_tmp) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_op)
            && $stable(mem_addr) && $stable(mem_wdata))
        else begin
            $error("memory request changed while stalled");
            assert_errors++;
        end

    a_one_side_busy: assert property (@(posedge clk_tmp) disable iff (rst)
        !(mem_req_valid && rsp_valid))
        else begin
            $error("memory request and response valid together");
            assert_errors++;
        end

endmodule

bind l2_cache l2_cache_checker u_checker (
    .clk_tmp(clk_tmp), .rst(rst), .req_ready(req_ready), .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata), .mem_req_valid(mem_req_valid),
    .mem_req_ready(mem_req_ready), .mem_op(mem_op), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata)
);

// File: tb_l2_cache.sv
/*
 Testbench for the L2 cache: memory model with back-pressure, shadow memory reference
 and a response comparator. Runs miss, hit, write, eviction and random traffic.
*/
module tb_l2_cache;
    timeunit 1ns;
    timeprecision 1ps;
    import l2_cache_pkg::*;

    localparam int RAND_REQS = 60;
    localparam int NUM_REQS = 17 + RAND_REQS;          // directed phases issue 17
    localparam int TIMEOUT_CYCLES = 400 * NUM_REQS;

    logic clk_tmp;
    logic rst;
    logic req_valid;
    logic req_write;
    logic req_ready;
    logic [ADDR_W-1:0] req_addr;
    logic [WORD_W-1:0] req_wdata;
    logic rsp_valid;
    logic rsp_ready;
    logic [WORD_W-1:0] rsp_rdata;
    logic mem_req_valid;
    logic mem_req_ready;
    logic mem_rsp_valid;
    mem_op_e mem_op;
    logic [LINE_ADDR_W-1:0] mem_addr;
    logic [LINE_W-1:0] mem_wdata;
    logic [LINE_W-1:0] mem_rdata;

    integer seed = 32'ha096;
    int errors = 0;
    int cycles = 0;
    int reads_seen = 0;
    int writes_seen = 0;
    logic rsp_bp = 1'b0;                               // random rsp_ready when set
    logic [LINE_ADDR_W-1:0] last_read;
    logic [LINE_W-1:0] backing [logic [LINE_ADDR_W-1:0]];
    logic [WORD_W-1:0] shadow [logic [ADDR_W-1:0]];    // keyed by word address
    logic wr_q[$];
    logic [WORD_W-1:0] exp_q[$];

    l2_cache dut0 (.*);

    function automatic logic [ADDR_W-1:0] make_addr(input int t, input int s, input int w);
        return {TAG_W'(t), INDEX_W'(s), OFFSET_W'(w), {OFFSET_LO{1'b0}}};
    endfunction

    function automatic logic [WORD_W-1:0] init_word(input logic [ADDR_W-1:0] a);
        return {a ^ 32'h9e3779b9, ~a, a * 32'h01000193, {a[15:0], a[31:16]}};
    endfunction

    function automatic logic [WORD_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] key;
        key = {addr[ADDR_W-1:OFFSET_LO], {OFFSET_LO{1'b0}}};
        if (shadow.exists(key)) begin
            return shadow[key];
        end
        return init_word(key);
    endfunction

    // whole line from the reference, or from the initial hash
    function automatic logic [LINE_W-1:0] build_line(input logic [LINE_ADDR_W-1:0] la,
                                                     input logic use_shadow);
        logic [LINE_W-1:0] line;
        logic [ADDR_W-1:0] a;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            a = {la, OFFSET_W'(w), {OFFSET_LO{1'b0}}};
            line[w*WORD_W +: WORD_W] = use_shadow ? expected_word(a) : init_word(a);
        end
        return line;
    endfunction

    task automatic check_equal(input logic [LINE_W-1:0] got, input logic [LINE_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic issue(input logic wr, input logic [ADDR_W-1:0] addr,
                         input logic [WORD_W-1:0] data, output int lat);
        int cyc;
        @(posedge clk_tmp);
        #5;
        req_valid = 1'b1;
        req_write = wr;
        req_addr = addr;
        req_wdata = data;
        do @(negedge clk_tmp); while (!req_ready);
        wr_q.push_back(wr);                            // accepted at the coming edge
        exp_q.push_back(expected_word(addr));
        if (wr) begin
            shadow[{addr[ADDR_W-1:OFFSET_LO], {OFFSET_LO{1'b0}}}] = data;
        end
        @(posedge clk_tmp);
        #5;
        req_valid = 1'b0;
        cyc = 0;
        lat = 0;
        do begin
            @(negedge clk_tmp);
            cyc++;
            if (rsp_valid && lat == 0) begin
                lat = cyc;                             // cycles after the accepting edge
            end
        end while (!(rsp_valid && rsp_ready));
    endtask

    initial begin
        clk_tmp = 1'b0;
        forever #50 clk_tmp = ~clk_tmp;
    end

    // memory model plus random back-pressure on both ready inputs
    initial begin
        int wait_cnt;
        logic [LINE_ADDR_W-1:0] fill_addr;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rdata = '0;
        rsp_ready = 1'b1;
        wait_cnt = 0;
        forever begin
            @(negedge clk_tmp);
            if (mem_req_valid && mem_req_ready) begin
                if (mem_op == MEM_WRITE) begin
                    writes_seen++;
                    check_equal(mem_wdata, build_line(mem_addr, 1'b1), "writeback line");
                    backing[mem_addr] = mem_wdata;
                end else begin
                    reads_seen++;
                    last_read = mem_addr;
                    fill_addr = mem_addr;
                    wait_cnt = 1 + ($random(seed) & 3);  // 1 to 4 cycles
                end
            end
            @(posedge clk_tmp);
            #5;
            mem_rsp_valid = 1'b0;
            if (wait_cnt > 0) begin
                wait_cnt--;
                if (wait_cnt == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rdata = backing.exists(fill_addr) ? backing[fill_addr]
                                                         : build_line(fill_addr, 1'b0);
                end
            end
            mem_req_ready = ($random(seed) & 3) != 0;
            rsp_ready = !rsp_bp || (($random(seed) & 3) != 0);
        end
    end

    // response comparator
    initial begin
        logic w;
        logic [WORD_W-1:0] e;
        forever begin
            @(negedge clk_tmp);
            if (rsp_valid && rsp_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("response arrived with no request outstanding");
                end else begin
                    w = wr_q.pop_front();
                    e = exp_q.pop_front();
                    if (!w) begin
                        check_equal(rsp_rdata, e, "read data");
                    end
                end
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_tmp);
            cycles++;
        end
        $display("timeout: cache stopped responding");
        $display("Test failed");
        $finish;
    end

    initial begin
        int lat;
        int rd0;
        int wr0;
        logic [ADDR_W-1:0] a;
        rst = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        repeat (3) @(posedge clk_tmp);
        #5;
        rst = 1'b0;

        a = make_addr(22'h15, 0, 2);                   // cold read miss
        rd0 = reads_seen;
        wr0 = writes_seen;
        issue(1'b0, a, '0, lat);
        check_equal(reads_seen - rd0, 1, "read count on cold miss");
        check_equal(writes_seen - wr0, 0, "write count on cold miss");
        check_equal(last_read, a[ADDR_W-1:INDEX_LO], "fill line address");

        rd0 = reads_seen;
        issue(1'b0, make_addr(22'h15, 0, 1), '0, lat);  // hit, same line
        check_equal(reads_seen - rd0, 0, "memory read on hit");
        check_equal(lat, 2, "read hit latency");

        issue(1'b1, make_addr(22'h15, 0, 3), {4{32'hc0ffee11}}, lat);
        check_equal(lat, 2, "write hit latency");
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            issue(1'b0, make_addr(22'h15, 0, 3 - w), '0, lat);
        end

        wr0 = writes_seen;                             // five dirty lines in set 3
        for (int t = 0; t < 5; t++) begin
            issue(1'b1, make_addr(22'h100 + t, 3, t), {$random(seed), $random(seed),
                  $random(seed), $random(seed)}, lat);
        end
        check_equal(writes_seen - wr0, 1, "writebacks for dirty eviction");
        wr0 = writes_seen;                             // clean victims in set 5
        for (int t = 0; t < 5; t++) begin
            issue(1'b0, make_addr(22'h200 + t, 5, t), '0, lat);
        end
        check_equal(writes_seen - wr0, 0, "writebacks for clean eviction");

        rsp_bp = 1'b1;
        for (int i = 0; i < RAND_REQS; i++) begin
            issue($random(seed) & 1, make_addr(22'h300 + ($random(seed) & 7),
                  6 + ($random(seed) & 1), $random(seed) & 3),
                  {$random(seed), $random(seed), $random(seed), $random(seed)}, lat);
        end
        repeat (2) @(posedge clk_tmp);

        $display("check errors: %0d, assertion errors: %0d, pending responses: %0d",
                 errors, dut0.u_checker.assert_errors, exp_q.size());
        if (errors == 0 && dut0.u_checker.assert_errors == 0 && exp_q.size() == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: project.f
l2_cache_pkg.sv
l2_tag_dir.sv
l2_data_store.sv
l2_cache_ctrl.sv
l2_cache.sv
l2_cache_checker.sv
tb_l2_cache.sv
